// ==== Makefile ====
# Verilator build and run of the rv_core testbench
TOP       ?= tb_rv_core
VERILATOR ?= verilator
SEED_LOG  ?= sim.log
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(SEED_LOG)"
	@echo "  clean  remove build output and log"
	@echo "variables: TOP VERILATOR SEED_LOG FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(SEED_LOG)
	@grep -q "TEST PASS" $(SEED_LOG)

clean:
	rm -rf $(BUILD_DIR) $(SEED_LOG)

// ==== hdl/alu.sv ====
// 64-bit integer alu with word ops and the branch compare, purely combinational
`timescale 1ns/1ps

module alu import rv_pkg::*; (
	input  alu_op_e alu_op,
	input  xlen_t   op1,
	input  xlen_t   op2,
	output xlen_t   result,
	output logic    taken
);

	logic [31:0] word_res;

	// low 32 bits only, sign extended below
	always_comb begin
		case (alu_op)
			alu_addw: word_res = op1[31:0] + op2[31:0];
			alu_subw: word_res = op1[31:0] - op2[31:0];
			alu_sllw: word_res = op1[31:0] << op2[4:0];
			alu_srlw: word_res = op1[31:0] >> op2[4:0];
			alu_sraw: word_res = $signed(op1[31:0]) >>> op2[4:0];
			default:  word_res = '0;
		endcase
	end

	always_comb begin
		case (alu_op)
			alu_add:  result = op1 + op2;
			alu_sub:  result = op1 - op2;
			alu_sll:  result = op1 << op2[5:0];
			alu_slt:  result = {63'b0, $signed(op1) < $signed(op2)};
			alu_sltu: result = {63'b0, op1 < op2};
			alu_xor:  result = op1 ^ op2;
			alu_srl:  result = op1 >> op2[5:0];
			alu_sra:  result = $signed(op1) >>> op2[5:0];
			alu_or:   result = op1 | op2;
			alu_and:  result = op1 & op2;
			alu_lui:  result = op2;
			alu_addw, alu_subw, alu_sllw, alu_srlw, alu_sraw:
				result = {{32{word_res[31]}}, word_res};
			default:  result = '0;
		endcase
	end

	always_comb begin
		case (alu_op)
			alu_beq:  taken = op1 == op2;
			alu_bne:  taken = op1 != op2;
			alu_blt:  taken = $signed(op1) < $signed(op2);
			alu_bge:  taken = $signed(op1) >= $signed(op2);
			alu_bltu: taken = op1 < op2;
			alu_bgeu: taken = op1 >= op2;
			default:  taken = 1'b0;
		endcase
	end

endmodule

// ==== hdl/core_ctrl.sv ====
// core sequencer, holds pc, instruction register and the fetch/exec/mem/wb state machine
`timescale 1ns/1ps

module core_ctrl import rv_pkg::*; #(
	parameter xlen_t RESET_PC = '0
) (
	input  logic    clk,
	input  logic    rst,
	output xlen_t   imem_addr,
	input  inst_t   imem_data,
	output inst_t   inst,
	output xlen_t   pc,
	input  decode_t dec,
	input  logic    taken,
	input  xlen_t   rs1_data,
	output logic    req_en,
	input  logic    dmem_ready,
	output logic    rd_we
);

	core_state_e state;
	xlen_t       next_pc;
	xlen_t       jalr_sum;
	logic        is_mem;

	assign is_mem    = dec.mem_r_ena | dec.mem_w_ena;
	assign imem_addr = pc;
	assign req_en    = state == st_mem;
	// loads write in st_wb, everything else at the end of st_exec
	assign rd_we     = dec.rd_ena & ((state == st_exec & ~is_mem) | state == st_wb);

	assign jalr_sum = rs1_data + dec.j_offset;

	always_comb begin
		if (dec.jump[0])
			next_pc = {jalr_sum[63:1], 1'b0};
		else if (dec.jump[1])
			next_pc = pc + dec.j_offset;
		else if (dec.branch && taken)
			next_pc = pc + dec.b_offset;
		else
			next_pc = pc + 64'd4;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_fetch;
			pc    <= RESET_PC;
		end else begin
			case (state)
				st_fetch: state <= st_exec;
				st_exec: begin
					if (is_mem) begin
						state <= st_mem;
					end else begin
						pc    <= next_pc;
						state <= st_fetch;
					end
				end
				st_mem: begin
					if (dmem_ready) begin
						if (dec.mem_r_ena) begin
							state <= st_wb;
						end else begin
							pc    <= next_pc; // store done
							state <= st_fetch;
						end
					end
				end
				default: begin // st_wb
					pc    <= next_pc;
					state <= st_fetch;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_fetch)
			inst <= imem_data;
	end

	// request and the decode behind it are held until memory takes it
	assert property (@(posedge clk) disable iff (rst)
		req_en && !dmem_ready |=> req_en && $stable(dec));

endmodule

// ==== hdl/id_stage.sv ====
// instruction decoder, turns the latched instruction and register data into one decode_t word
`timescale 1ns/1ps

module id_stage import rv_pkg::*; (
	input  inst_t   inst,
	input  xlen_t   pc,
	input  xlen_t   rs1_data,
	input  xlen_t   rs2_data,
	output decode_t dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;
	strb_t      width_mask;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{52{inst[31]}}, inst[31:20]};
	assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
	assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		case (funct3)
			f3_lb, f3_lbu: width_mask = 8'h01;
			f3_lh, f3_lhu: width_mask = 8'h03;
			f3_lw, f3_lwu: width_mask = 8'h0f;
			f3_ld:         width_mask = 8'hff;
			default:       width_mask = 8'h00;
		endcase
	end

	always_comb begin
		dec          = '0;
		dec.alu_op   = alu_zero;
		dec.rd_addr  = inst[11:7];
		dec.branch   = opcode == opc_branch;
		dec.b_offset = imm_b;
		dec.jump     = {opcode == opc_jal, opcode == opc_jalr};
		dec.j_offset = dec.jump[0] ? imm_i : (dec.jump[1] ? imm_j : '0);

		case (opcode)
			opc_op, opc_op32: begin
				dec.rs1_ena = 1'b1;
				dec.rs2_ena = 1'b1;
				dec.rd_ena  = 1'b1;
				dec.op1     = rs1_data;
				dec.op2     = rs2_data;
				if (opcode == opc_op32) begin
					case (funct3)
						f3_add_sub: dec.alu_op = funct7[5] ? alu_subw : alu_addw;
						f3_sll:     dec.alu_op = alu_sllw;
						f3_sr:      dec.alu_op = funct7[5] ? alu_sraw : alu_srlw;
						default:    dec.alu_op = alu_zero;
					endcase
				end else begin
					case (funct3)
						f3_add_sub: dec.alu_op = funct7[5] ? alu_sub : alu_add;
						f3_sll:     dec.alu_op = alu_sll;
						f3_slt:     dec.alu_op = alu_slt;
						f3_sltu:    dec.alu_op = alu_sltu;
						f3_xor:     dec.alu_op = alu_xor;
						f3_sr:      dec.alu_op = funct7[5] ? alu_sra : alu_srl;
						f3_or:      dec.alu_op = alu_or;
						default:    dec.alu_op = alu_and;
					endcase
				end
			end
			opc_op_imm: begin
				dec.rs1_ena = 1'b1;
				dec.rd_ena  = 1'b1;
				dec.op1     = rs1_data;
				dec.op2     = imm_i;
				case (funct3)
					f3_add_sub: dec.alu_op = alu_add;
					f3_slt:     dec.alu_op = alu_slt;
					f3_sltu:    dec.alu_op = alu_sltu;
					f3_xor:     dec.alu_op = alu_xor;
					f3_or:      dec.alu_op = alu_or;
					f3_and:     dec.alu_op = alu_and;
					f3_sll: begin
						dec.alu_op = alu_sll;
						dec.op2    = {58'b0, inst[25:20]}; // 6-bit shamt
					end
					default: begin
						dec.alu_op = funct7[5] ? alu_sra : alu_srl;
						dec.op2    = {58'b0, inst[25:20]};
					end
				endcase
			end
			opc_op_imm32: begin
				dec.rs1_ena = 1'b1;
				dec.rd_ena  = 1'b1;
				dec.op1     = rs1_data;
				dec.op2     = imm_i;
				case (funct3)
					f3_add_sub: dec.alu_op = alu_addw;
					f3_sll: begin
						dec.alu_op = alu_sllw;
						dec.op2    = {59'b0, inst[24:20]};
					end
					f3_sr: begin
						dec.alu_op = funct7[5] ? alu_sraw : alu_srlw;
						dec.op2    = {59'b0, inst[24:20]};
					end
					default: dec.alu_op = alu_zero;
				endcase
			end
			opc_lui: begin
				dec.rd_ena = 1'b1;
				dec.op2    = imm_u;
				dec.alu_op = alu_lui;
			end
			opc_auipc: begin
				dec.rd_ena = 1'b1;
				dec.op1    = pc;
				dec.op2    = imm_u;
				dec.alu_op = alu_add;
			end
			opc_jal, opc_jalr: begin
				dec.rs1_ena = dec.jump[0]; // target base for jalr only
				dec.rd_ena  = 1'b1;
				dec.op1     = pc;          // link value pc + 4
				dec.op2     = 64'd4;
				dec.alu_op  = alu_add;
			end
			opc_branch: begin
				dec.rs1_ena = 1'b1;
				dec.rs2_ena = 1'b1;
				dec.op1     = rs1_data;
				dec.op2     = rs2_data;
				case (funct3)
					f3_beq:  dec.alu_op = alu_beq;
					f3_bne:  dec.alu_op = alu_bne;
					f3_blt:  dec.alu_op = alu_blt;
					f3_bge:  dec.alu_op = alu_bge;
					f3_bltu: dec.alu_op = alu_bltu;
					f3_bgeu: dec.alu_op = alu_bgeu;
					default: dec.alu_op = alu_zero;
				endcase
			end
			opc_load: begin
				dec.rs1_ena     = 1'b1;
				dec.rd_ena      = 1'b1;
				dec.op1         = rs1_data;
				dec.op2         = imm_i;
				dec.alu_op      = alu_add;
				dec.mem_r_ena   = 1'b1;
				dec.mem_to_reg  = 1'b1;
				dec.byte_enable = width_mask;
				dec.mem_ext_un  = funct3 inside {f3_lbu, f3_lhu, f3_lwu};
			end
			opc_store: begin
				dec.rs1_ena     = 1'b1;
				dec.rs2_ena     = 1'b1;
				dec.op1         = rs1_data;
				dec.op2         = imm_s;
				dec.alu_op      = alu_add;
				dec.mem_w_ena   = 1'b1;
				dec.byte_enable = width_mask;
			end
			default: ;
		endcase

		// unused read ports look at x0
		dec.rs1_addr = dec.rs1_ena ? inst[19:15] : '0;
		dec.rs2_addr = dec.rs2_ena ? inst[24:20] : '0;
	end

endmodule

// ==== hdl/lsu.sv ====
// load/store unit, forms the data memory request and the write-back value
`timescale 1ns/1ps

module lsu import rv_pkg::*; (
	input  decode_t   dec,
	input  xlen_t     addr,
	input  xlen_t     store_data,
	input  logic      req_en,
	output dmem_req_t dmem_req,
	input  xlen_t     dmem_rdata,
	output xlen_t     wb_data,
	input  xlen_t     alu_result
);

	logic [2:0]  offset;
	logic [15:0] wide_strb; // upper byte catches accesses crossing the line
	xlen_t       rd_shift;
	xlen_t       load_val;

	assign offset    = addr[2:0];
	assign wide_strb = {8'b0, dec.byte_enable} << offset;

	assign dmem_req.valid = req_en & (dec.mem_r_ena | dec.mem_w_ena);
	assign dmem_req.we    = dec.mem_w_ena;
	assign dmem_req.addr  = addr;
	assign dmem_req.wdata = store_data << {offset, 3'b000};
	assign dmem_req.strb  = wide_strb[7:0];

	assign rd_shift = dmem_rdata >> {offset, 3'b000};

	always_comb begin
		case (dec.byte_enable)
			8'h01:   load_val = {{56{~dec.mem_ext_un & rd_shift[7]}}, rd_shift[7:0]};
			8'h03:   load_val = {{48{~dec.mem_ext_un & rd_shift[15]}}, rd_shift[15:0]};
			8'h0f:   load_val = {{32{~dec.mem_ext_un & rd_shift[31]}}, rd_shift[31:0]};
			default: load_val = rd_shift; // ld
		endcase
	end

	assign wb_data = dec.mem_to_reg ? load_val : alu_result;

	// address offset plus width has to stay inside one 8-byte line
	always_comb begin
		if (dmem_req.valid)
			assert (wide_strb[15:8] == 8'h00)
				else $error("misaligned access at %h", addr);
	end

endmodule

// ==== hdl/regfile.sv ====
// integer register file, x0 reads zero, two async read ports and one clocked write port
`timescale 1ns/1ps

module regfile import rv_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  reg_addr_t rs1_addr,
	input  reg_addr_t rs2_addr,
	output xlen_t     rs1_data,
	output xlen_t     rs2_data,
	input  logic      we,
	input  reg_addr_t rd_addr,
	input  xlen_t     rd_data
);

	xlen_t regs [1:31];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we && rd_addr != '0) begin
			regs[rd_addr] <= rd_data;
		end
	end

	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== hdl/rv_core.sv ====
// top level of the multi-cycle rv64i core, instruction and data ports face the system
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
	parameter xlen_t RESET_PC = '0
) (
	input  logic      clk,
	input  logic      rst,
	output xlen_t     imem_addr,
	input  inst_t     imem_data,
	output dmem_req_t dmem_req,
	input  logic      dmem_ready,
	input  xlen_t     dmem_rdata
);

	inst_t   inst;
	xlen_t   pc;
	decode_t dec;
	xlen_t   rs1_data, rs2_data;
	xlen_t   alu_result;
	logic    taken;
	logic    req_en;
	logic    rd_we;
	xlen_t   wb_data;

	core_ctrl #(.RESET_PC(RESET_PC)) u_ctrl (
		.clk(clk), .rst(rst),
		.imem_addr(imem_addr), .imem_data(imem_data),
		.inst(inst), .pc(pc),
		.dec(dec), .taken(taken), .rs1_data(rs1_data),
		.req_en(req_en), .dmem_ready(dmem_ready), .rd_we(rd_we)
	);

	id_stage u_id (
		.inst(inst), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .dec(dec)
	);

	regfile u_rf (
		.clk(clk), .rst(rst),
		.rs1_addr(dec.rs1_addr), .rs2_addr(dec.rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.we(rd_we), .rd_addr(dec.rd_addr), .rd_data(wb_data)
	);

	alu u_alu (
		.alu_op(dec.alu_op), .op1(dec.op1), .op2(dec.op2),
		.result(alu_result), .taken(taken)
	);

	lsu u_lsu (
		.dec(dec), .addr(alu_result), .store_data(rs2_data), .req_en(req_en),
		.dmem_req(dmem_req), .dmem_rdata(dmem_rdata),
		.wb_data(wb_data), .alu_result(alu_result)
	);

endmodule

// ==== hdl/rv_pkg.sv ====
// shared widths, encodings and structs of the rv64i core, imported by every module under hdl
package rv_pkg;

	localparam int xlen = 64;

	typedef logic [xlen-1:0] xlen_t;
	typedef logic [31:0]     inst_t;
	typedef logic [4:0]      reg_addr_t;
	typedef logic [7:0]      strb_t;

	typedef enum logic [4:0] {
		alu_zero, alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl,
		alu_sra, alu_or, alu_and, alu_lui, alu_addw, alu_subw, alu_sllw, alu_srlw,
		alu_sraw, alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
	} alu_op_e;

	typedef enum logic [1:0] {st_fetch, st_exec, st_mem, st_wb} core_state_e;

	typedef struct packed {
		logic      rs1_ena;
		reg_addr_t rs1_addr;
		logic      rs2_ena;
		reg_addr_t rs2_addr;
		logic      rd_ena;
		reg_addr_t rd_addr;
		alu_op_e   alu_op;
		xlen_t     op1;
		xlen_t     op2;
		logic      branch;
		xlen_t     b_offset;
		logic [1:0] jump;       // bit 0 jalr, bit 1 jal
		xlen_t     j_offset;
		logic      mem_r_ena;
		logic      mem_w_ena;
		logic      mem_to_reg;
		strb_t     byte_enable; // width mask, not yet shifted by address
		logic      mem_ext_un;
	} decode_t;

	typedef struct packed {
		logic  valid;
		logic  we;
		xlen_t addr;
		xlen_t wdata;
		strb_t strb;
	} dmem_req_t;

	localparam logic [6:0] opc_op       = 7'b0110011;
	localparam logic [6:0] opc_op_imm   = 7'b0010011;
	localparam logic [6:0] opc_op32     = 7'b0111011;
	localparam logic [6:0] opc_op_imm32 = 7'b0011011;
	localparam logic [6:0] opc_lui      = 7'b0110111;
	localparam logic [6:0] opc_auipc    = 7'b0010111;
	localparam logic [6:0] opc_jal      = 7'b1101111;
	localparam logic [6:0] opc_jalr     = 7'b1100111;
	localparam logic [6:0] opc_branch   = 7'b1100011;
	localparam logic [6:0] opc_load     = 7'b0000011;
	localparam logic [6:0] opc_store    = 7'b0100011;

	// integer ops
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_sr      = 3'b101;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	// branches
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	// loads, stores reuse the low four codes
	localparam logic [2:0] f3_lb  = 3'b000;
	localparam logic [2:0] f3_lh  = 3'b001;
	localparam logic [2:0] f3_lw  = 3'b010;
	localparam logic [2:0] f3_ld  = 3'b011;
	localparam logic [2:0] f3_lbu = 3'b100;
	localparam logic [2:0] f3_lhu = 3'b101;
	localparam logic [2:0] f3_lwu = 3'b110;

endpackage

// ==== rv_core.f ====
hdl/rv_pkg.sv
hdl/id_stage.sv
hdl/regfile.sv
hdl/alu.sv
hdl/lsu.sv
hdl/core_ctrl.sv
hdl/rv_core.sv
verif/tb_rv_core.sv

// ==== verif/tb_rv_core.sv ====
// testbench for rv_core, runs small directed programs and checks every store the core issues
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

	localparam xlen_t reset_pc       = 64'h200;
	localparam xlen_t data_base      = 64'h400; // x10 points here in every program
	localparam xlen_t load_base      = 64'h500;
	localparam int    timeout_cycles = 2000;

	logic      clk = 1'b0;
	logic      rst = 1'b1;
	xlen_t     imem_addr;
	inst_t     imem_data;
	dmem_req_t dmem_req;
	logic      dmem_ready = 1'b0;
	xlen_t     dmem_rdata = '0;

	inst_t       imem [0:1023];
	xlen_t       dmem [0:255];
	logic        busy = 1'b0;
	int          wait_cnt = 0;
	logic [31:0] lcg_state = 32'd32;

	// stores seen on the bus
	xlen_t st_addr [$];
	xlen_t st_data [$];
	strb_t st_strb [$];
	xlen_t exp_addr [$];
	xlen_t exp_data [$];
	strb_t exp_strb [$];

	int prog_idx;
	int slot;
	int test_errs;
	int pass_cnt = 0;
	int fail_cnt = 0;

	rv_core #(.RESET_PC(reset_pc)) uut (
		.clk(clk), .rst(rst),
		.imem_addr(imem_addr), .imem_data(imem_data),
		.dmem_req(dmem_req), .dmem_ready(dmem_ready), .dmem_rdata(dmem_rdata)
	);

	always #5 clk = ~clk;

	// a misaligned fetch sees a halt
	assign imem_data = (imem_addr[1:0] == 2'b00) ? imem[imem_addr[11:2]] : j_type(0, 0);

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_delay();
		logic [31:0] r;
		r = next_rand();
		return int'(r[29:28]); // 0 to 3 cycles
	endfunction

	// data memory, random ready delay, write on the handshake edge
	always @(posedge clk) begin
		int    d;
		int    idx;
		xlen_t word;
		if (rst) begin
			dmem_ready <= 1'b0;
			busy       <= 1'b0;
		end else if (dmem_ready) begin
			dmem_ready <= 1'b0;
			busy       <= 1'b0;
			if (dmem_req.valid && dmem_req.we) begin
				idx  = int'(dmem_req.addr[10:3]);
				word = dmem[idx];
				for (int b = 0; b < 8; b++)
					if (dmem_req.strb[b])
						word[b*8 +: 8] = dmem_req.wdata[b*8 +: 8];
				dmem[idx] = word;
				st_addr.push_back(dmem_req.addr);
				st_data.push_back(dmem_req.wdata);
				st_strb.push_back(dmem_req.strb);
			end
		end else if (dmem_req.valid) begin
			d    = busy ? wait_cnt : rand_delay();
			busy <= 1'b1;
			if (d == 0) begin
				dmem_ready <= 1'b1;
				dmem_rdata <= dmem[int'(dmem_req.addr[10:3])];
			end else begin
				wait_cnt <= d - 1;
			end
		end
	end

	function automatic inst_t r_type(int f7, int rs2, int rs1, int f3, int rd, logic [6:0] opc);
		return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), opc};
	endfunction

	function automatic inst_t i_type(int imm, int rs1, int f3, int rd, logic [6:0] opc);
		return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), opc};
	endfunction

	function automatic inst_t s_type(int imm, int rs2, int rs1, int f3);
		logic [11:0] i;
		i = 12'(imm);
		return {i[11:5], 5'(rs2), 5'(rs1), 3'(f3), i[4:0], opc_store};
	endfunction

	function automatic inst_t b_type(int imm, int rs2, int rs1, int f3);
		logic [12:0] i;
		i = 13'(imm);
		return {i[12], i[10:5], 5'(rs2), 5'(rs1), 3'(f3), i[4:1], i[11], opc_branch};
	endfunction

	function automatic inst_t u_type(int imm, int rd, logic [6:0] opc);
		return {20'(imm), 5'(rd), opc};
	endfunction

	function automatic inst_t j_type(int imm, int rd);
		logic [20:0] i;
		i = 21'(imm);
		return {i[20], i[10:1], i[11], i[19:12], 5'(rd), opc_jal};
	endfunction

	function automatic xlen_t sext32(logic [31:0] w);
		return {{32{w[31]}}, w};
	endfunction

	// bytes at offset, zero or sign extended from the access width
	function automatic xlen_t load_value(xlen_t w, int off, int nb, bit un);
		xlen_t v;
		xlen_t keep;
		v = w >> (off * 8);
		if (nb < 8) begin
			keep = (64'd1 << (nb * 8)) - 64'd1;
			v    = v & keep;
			if (!un && v[nb*8-1])
				v = v | ~keep;
		end
		return v;
	endfunction

	task automatic check_word(string name, xlen_t exp, xlen_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_strb(string name, strb_t exp, strb_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("Fail %s: expected %b, actual %b", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic emit(inst_t i);
		imem[prog_idx] = i;
		prog_idx++;
	endtask

	function automatic xlen_t cur_pc();
		return 64'(prog_idx) * 64'd4;
	endfunction

	task automatic expect_store(xlen_t addr, xlen_t data, strb_t strb);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_strb.push_back(strb);
	endtask

	// sd rd into the next result slot
	task automatic store_result(int rd, xlen_t exp);
		emit(s_type(slot * 8, rd, 10, f3_ld));
		expect_store(data_base + 64'(slot * 8), exp, 8'hff);
		slot++;
	endtask

	// holds the core in reset while a new program is written
	task automatic begin_test();
		@(posedge clk);
		rst <= 1'b1;
		for (int i = 0; i < 1024; i++)
			imem[i] = j_type(0, 0); // jal x0, 0 halts
		prog_idx  = int'(reset_pc[11:2]);
		slot      = 0;
		test_errs = 0;
		exp_addr.delete();
		exp_data.delete();
		exp_strb.delete();
		emit(i_type(int'(data_base), 0, f3_add_sub, 10, opc_op_imm));
	endtask

	task automatic run_and_check(string name);
		int n;
		int cycles;
		n = exp_addr.size();
		repeat (4) @(posedge clk);
		@(posedge clk);
		rst <= 1'b0; // fifth reset edge
		st_addr.delete();
		st_data.delete();
		st_strb.delete();
		cycles = 0;
		while (st_addr.size() < n && cycles < timeout_cycles) begin
			@(posedge clk);
			cycles++;
		end
		if (st_addr.size() < n) begin
			$display("%s: timed out waiting for store %0d of %0d", name, st_addr.size() + 1, n);
			test_errs++;
		end
		for (int i = 0; i < n && i < st_addr.size(); i++) begin
			check_word($sformatf("%s store %0d addr", name, i), exp_addr[i], st_addr[i]);
			check_word($sformatf("%s store %0d data", name, i), exp_data[i], st_data[i]);
			check_strb($sformatf("%s store %0d strb", name, i), exp_strb[i], st_strb[i]);
		end
	endtask

	task automatic finish_test(string name);
		if (test_errs == 0) begin
			pass_cnt++;
			$display("%s: ok", name);
		end else begin
			fail_cnt++;
			$display("%s: %0d errors", name, test_errs);
		end
	endtask

	task automatic run_reset();
		begin_test();
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			@(negedge clk);
			check_flag("reset valid", 1'b0, dmem_req.valid);
		end
		@(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_flag("reset valid after release", 1'b0, dmem_req.valid);
		check_word("reset first fetch", reset_pc, imem_addr);
		finish_test("reset");
	endtask

	task automatic arith_ops();
		logic [31:0] r;
		logic [11:0] ia;
		logic [11:0] ib;
		xlen_t       a;
		xlen_t       b;
		begin_test();
		for (int round = 0; round < 2; round++) begin
			r  = next_rand();
			ia = r[27:16];
			r  = next_rand();
			ib = r[27:16];
			a  = {{52{ia[11]}}, ia};
			b  = {{52{ib[11]}}, ib};
			emit(i_type(int'(ia), 0, f3_add_sub, 1, opc_op_imm));
			emit(i_type(int'(ib), 0, f3_add_sub, 2, opc_op_imm));
			emit(r_type(0, 2, 1, f3_add_sub, 3, opc_op));
			store_result(3, a + b);
			emit(r_type(32, 2, 1, f3_add_sub, 3, opc_op));
			store_result(3, a - b);
			emit(r_type(0, 2, 1, f3_xor, 3, opc_op));
			store_result(3, a ^ b);
			emit(r_type(0, 2, 1, f3_or, 3, opc_op));
			store_result(3, a | b);
			emit(r_type(0, 2, 1, f3_and, 3, opc_op));
			store_result(3, a & b);
			emit(r_type(0, 2, 1, f3_slt, 3, opc_op));
			store_result(3, ($signed(a) < $signed(b)) ? 64'd1 : 64'd0);
			emit(r_type(0, 2, 1, f3_sltu, 3, opc_op));
			store_result(3, (a < b) ? 64'd1 : 64'd0);
			emit(r_type(0, 2, 1, f3_sll, 3, opc_op));
			store_result(3, a << b[5:0]);
			emit(r_type(0, 2, 1, f3_sr, 3, opc_op));
			store_result(3, a >> b[5:0]);
			emit(r_type(32, 2, 1, f3_sr, 3, opc_op));
			store_result(3, $signed(a) >>> b[5:0]);
		end
		run_and_check("arith");
		finish_test("arith");
	endtask

	task automatic word_ops();
		xlen_t a;
		xlen_t b;
		xlen_t c;
		xlen_t d;
		a = 64'h7ffff7f0;
		b = 64'h1000;
		c = 64'h7e5;               // shamt 5 in the low bits
		d = 64'hffffffff80000000;
		begin_test();
		emit(u_type(32'h7ffff, 1, opc_lui));
		emit(i_type(12'h7f0, 1, f3_add_sub, 1, opc_op_imm));
		emit(u_type(1, 2, opc_lui));
		emit(i_type(12'h7e5, 0, f3_add_sub, 3, opc_op_imm));
		emit(u_type(32'h80000, 5, opc_lui));
		emit(r_type(0, 2, 1, f3_add_sub, 4, opc_op32));
		store_result(4, sext32(a[31:0] + b[31:0]));
		emit(r_type(32, 1, 2, f3_add_sub, 4, opc_op32));
		store_result(4, sext32(b[31:0] - a[31:0]));
		emit(r_type(0, 3, 1, f3_sll, 4, opc_op32));
		store_result(4, sext32(a[31:0] << c[4:0]));
		emit(r_type(0, 3, 5, f3_sr, 4, opc_op32));
		store_result(4, sext32(d[31:0] >> c[4:0]));
		emit(r_type(32, 3, 5, f3_sr, 4, opc_op32));
		store_result(4, sext32($signed(d[31:0]) >>> c[4:0]));
		emit(i_type(-1, 5, f3_add_sub, 4, opc_op_imm32)); // addiw wraps to positive
		store_result(4, sext32(d[31:0] - 32'd1));
		emit(i_type(3, 1, f3_sll, 4, opc_op_imm32));
		store_result(4, sext32(a[31:0] << 3));
		emit(i_type(4, 5, f3_sr, 4, opc_op_imm32));
		store_result(4, sext32(d[31:0] >> 4));
		emit(i_type(12'h404, 5, f3_sr, 4, opc_op_imm32));
		store_result(4, sext32($signed(d[31:0]) >>> 4));
		run_and_check("word ops");
		finish_test("word ops");
	endtask

	task automatic store_at(logic [2:0] f3, int nbytes, int off);
		strb_t mask;
		mask = strb_t'((9'd1 << nbytes) - 9'd1);
		emit(s_type(slot * 8 + off, 6, 10, f3));
		expect_store(data_base + 64'(slot * 8 + off), 64'h1234567812345678 << (off * 8),
			strb_t'(mask << off));
		slot++;
	endtask

	task automatic store_strobes();
		begin_test();
		emit(u_type(32'h12345, 6, opc_lui));
		emit(i_type(12'h678, 6, f3_add_sub, 6, opc_op_imm));
		emit(i_type(32, 6, f3_sll, 7, opc_op_imm));
		emit(r_type(0, 7, 6, f3_or, 6, opc_op)); // x6 = 0x1234567812345678
		store_at(f3_lb, 1, 0);
		store_at(f3_lb, 1, 3);
		store_at(f3_lb, 1, 7);
		store_at(f3_lh, 2, 2);
		store_at(f3_lh, 2, 6);
		store_at(f3_lw, 4, 4);
		store_at(f3_lw, 4, 0);
		store_at(f3_ld, 8, 0);
		run_and_check("store strobes");
		finish_test("store strobes");
	endtask

	task automatic load_at(logic [2:0] f3, int nbytes, bit un, int off, xlen_t word);
		emit(i_type(off, 12, f3, 11, opc_load));
		store_result(11, load_value(word, off, nbytes, un));
	endtask

	task automatic load_ext();
		xlen_t word;
		word = 64'h7f86_1234_f0e1_82c3;
		begin_test();
		dmem[int'(load_base[10:3])] = word;
		emit(i_type(int'(load_base), 0, f3_add_sub, 12, opc_op_imm));
		load_at(f3_lb, 1, 1'b0, 1, word);
		load_at(f3_lbu, 1, 1'b1, 1, word);
		load_at(f3_lb, 1, 1'b0, 7, word);
		load_at(f3_lh, 2, 1'b0, 2, word);
		load_at(f3_lhu, 2, 1'b1, 2, word);
		load_at(f3_lh, 2, 1'b0, 6, word);
		load_at(f3_lw, 4, 1'b0, 0, word);
		load_at(f3_lwu, 4, 1'b1, 0, word);
		load_at(f3_lw, 4, 1'b0, 4, word);
		load_at(f3_ld, 8, 1'b0, 0, word);
		run_and_check("loads");
		finish_test("loads");
	endtask

	// marker in x20 comes from whichever path the branch took
	task automatic branch_block(logic [2:0] f3, int rs1, int rs2, bit taken);
		int hit;
		int miss;
		hit  = 100 + slot;
		miss = 300 + slot;
		emit(b_type(12, rs2, rs1, f3));
		emit(i_type(miss, 0, f3_add_sub, 20, opc_op_imm));
		emit(j_type(8, 0));
		emit(i_type(hit, 0, f3_add_sub, 20, opc_op_imm));
		store_result(20, taken ? 64'(hit) : 64'(miss));
	endtask

	task automatic control_flow();
		xlen_t p;
		begin_test();
		emit(i_type(5, 0, f3_add_sub, 1, opc_op_imm));
		emit(i_type(-3, 0, f3_add_sub, 2, opc_op_imm));
		emit(i_type(5, 0, f3_add_sub, 3, opc_op_imm));
		branch_block(f3_beq, 1, 3, 1'b1);
		branch_block(f3_beq, 1, 2, 1'b0);
		branch_block(f3_bne, 1, 2, 1'b1);
		branch_block(f3_bne, 1, 3, 1'b0);
		branch_block(f3_blt, 2, 1, 1'b1);
		branch_block(f3_blt, 1, 2, 1'b0);
		branch_block(f3_bge, 1, 2, 1'b1);
		branch_block(f3_bge, 2, 1, 1'b0);
		branch_block(f3_bltu, 1, 2, 1'b1);
		branch_block(f3_bltu, 2, 1, 1'b0);
		branch_block(f3_bgeu, 2, 1, 1'b1);
		branch_block(f3_bgeu, 1, 2, 1'b0);
		// jal over a stray store of zero
		p = cur_pc();
		emit(j_type(8, 21));
		emit(s_type(slot * 8, 0, 10, f3_ld));
		store_result(21, p + 64'd4);
		// jalr target is rs1 + 6 with bit 0 dropped
		p = cur_pc();
		emit(i_type(int'(p + 64'd11), 0, f3_add_sub, 22, opc_op_imm));
		emit(i_type(6, 22, 3'b000, 23, opc_jalr));
		emit(s_type(slot * 8, 0, 10, f3_ld));
		emit(i_type(12'h77, 0, f3_add_sub, 23, opc_op_imm));
		store_result(23, p + 64'd8);
		run_and_check("control flow");
		finish_test("control flow");
	endtask

	initial begin
		for (int i = 0; i < 256; i++)
			dmem[i] = 64'h0123_4567_89ab_cdef ^ (64'(i) * 64'h0001_0003_0005_0007);
		run_reset();
		arith_ops();
		word_ops();
		store_strobes();
		load_ext();
		control_flow();
		$display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule
